// File: include/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address width of each AXI4-Lite port
`define MEM_ADDR_W		16

// data bus width
`define MEM_DATA_W		32

// implemented RAM words, byte addresses from 4*MEM_WORDS upward are unmapped
`define MEM_WORDS		4096

// clock cycles between two button samples
// about 3 ms at 95 MHz
`define DEBOUNCE_TICKS	285000

`endif

// File: verilog/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

	// one data word
	typedef logic [`MEM_DATA_W-1:0]		word_t;

	// one strobe per byte lane
	typedef logic [`MEM_DATA_W/8-1:0]	strb_t;

	// word address into the RAM
	typedef logic [$clog2(`MEM_WORDS)-1:0]	waddr_t;

	// AXI response codes in use
	typedef enum logic [1:0] {
		resp_okay	= 2'b00,
		resp_slverr	= 2'b10
	} axi_resp_t;

endpackage

// File: verilog/reset_debounce.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module reset_debounce
#(
	parameter			TICKS		= `DEBOUNCE_TICKS
)
(
	input	logic		clk,
	input	logic		reset,
	input	logic		reset_btn,
	output	logic		btn_reset
);

	localparam			CNT_W		= (TICKS > 1) ? $clog2(TICKS) : 1;

	logic	[CNT_W-1:0]	counter;
	logic	[3:0]		samples;
	logic				tick;

	assign tick = (counter == CNT_W'(TICKS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			counter		<= '0;
			samples		<= '0;
			btn_reset	<= 1'b0;
		end else if (tick) begin
			counter		<= '0;
			samples		<= {samples[2:0], reset_btn};

			// held for four samples
			if (samples == 4'b1111)
				btn_reset	<= 1'b1;
			// button let go
			else if (samples == 4'b1000)
				btn_reset	<= 1'b0;
		end else begin
			counter		<= counter + 1'b1;
		end
	end

endmodule

// File: verilog/axil_bram_ctrl.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axil_bram_ctrl
(
	input	logic						clk,
	input	logic						reset,

	// write address channel
	input	logic	[`MEM_ADDR_W-1:0]	awaddr,
	input	logic						awvalid,
	output	logic						awready,

	// write data channel
	input	mem_pkg::word_t				wdata,
	input	mem_pkg::strb_t				wstrb,
	input	logic						wvalid,
	output	logic						wready,

	// write response channel
	output	mem_pkg::axi_resp_t			bresp,
	output	logic						bvalid,
	input	logic						bready,

	// read address channel
	input	logic	[`MEM_ADDR_W-1:0]	araddr,
	input	logic						arvalid,
	output	logic						arready,

	// read data channel
	output	mem_pkg::word_t				rdata,
	output	mem_pkg::axi_resp_t			rresp,
	output	logic						rvalid,
	input	logic						rready,

	// RAM port
	output	logic						bram_en,
	output	mem_pkg::strb_t				bram_we,
	output	mem_pkg::waddr_t			bram_addr,
	output	mem_pkg::word_t				bram_wrdata,
	input	mem_pkg::word_t				bram_rddata
);

	typedef enum logic [1:0] {
		st_idle,
		st_wresp,
		st_rresp
	} state_t;

	state_t		state;
	logic		aw_in_range;
	logic		ar_in_range;
	logic		wr_hit;
	logic		rd_hit;

	assign aw_in_range	= (awaddr < (`MEM_WORDS * 4));
	assign ar_in_range	= (araddr < (`MEM_WORDS * 4));

	// RAM access happens in the ready cycle, payload is still held by the master
	assign wr_hit		= awready && aw_in_range;
	assign rd_hit		= arready && ar_in_range;

	assign bram_en		= wr_hit || rd_hit;
	assign bram_we		= wr_hit ? wstrb : '0;
	assign bram_wrdata	= wdata;
	assign bram_addr	= awready ? mem_pkg::waddr_t'(awaddr[`MEM_ADDR_W-1:2])
								  : mem_pkg::waddr_t'(araddr[`MEM_ADDR_W-1:2]);

	assign bvalid		= (state == st_wresp);
	assign rvalid		= (state == st_rresp);

	// RAM output holds since en stays low until the response is taken
	assign rdata		= (rresp == mem_pkg::resp_slverr) ? '0 : bram_rddata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state	<= st_idle;
			awready	<= 1'b0;
			wready	<= 1'b0;
			arready	<= 1'b0;
		end else begin
			awready	<= 1'b0;
			wready	<= 1'b0;
			arready	<= 1'b0;

			case (state)
				st_idle: begin
					if (awready)
						state	<= st_wresp;
					else if (arready)
						state	<= st_rresp;
					// write wins over read
					else if (awvalid && wvalid) begin
						awready	<= 1'b1;
						wready	<= 1'b1;
					end else if (arvalid)
						arready	<= 1'b1;
				end

				st_wresp: begin
					if (bready)
						state	<= st_idle;
				end

				st_rresp: begin
					if (rready)
						state	<= st_idle;
				end

				default: state	<= st_idle;
			endcase
		end
	end

	// response codes latched at acceptance
	always_ff @(posedge clk) begin
		if (state == st_idle && awready)
			bresp	<= aw_in_range ? mem_pkg::resp_okay : mem_pkg::resp_slverr;

		if (state == st_idle && arready)
			rresp	<= ar_in_range ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
	end

endmodule

// File: verilog/dual_port_bram.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module dual_port_bram
(
	input	logic				clk,

	// port a
	input	logic				ena,
	input	mem_pkg::strb_t		wea,
	input	mem_pkg::waddr_t	addra,
	input	mem_pkg::word_t		dina,
	output	mem_pkg::word_t		douta,

	// port b
	input	logic				enb,
	input	mem_pkg::strb_t		web,
	input	mem_pkg::waddr_t	addrb,
	input	mem_pkg::word_t		dinb,
	output	mem_pkg::word_t		doutb
);

	localparam	LANES	= $bits(mem_pkg::strb_t);

	mem_pkg::word_t		mem [0:`MEM_WORDS-1];

	// read-first, outputs hold while the port is idle
	always_ff @(posedge clk) begin
		if (ena) begin
			douta	<= mem[addra];
			for (int i = 0; i < LANES; i++) begin
				if (wea[i])
					mem[addra][i*8 +: 8]	<= dina[i*8 +: 8];
			end
		end

		// same word from both ports in one cycle is left undefined
		if (enb) begin
			doutb	<= mem[addrb];
			for (int i = 0; i < LANES; i++) begin
				if (web[i])
					mem[addrb][i*8 +: 8]	<= dinb[i*8 +: 8];
			end
		end
	end

endmodule

// File: verilog/fpga_mem_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module fpga_mem_top
#(
	parameter							DEBOUNCE_TICKS	= `DEBOUNCE_TICKS
)
(
	input	logic						clk,
	input	logic						reset,
	input	logic						reset_btn,

	// imem port
	input	logic	[`MEM_ADDR_W-1:0]	imem_awaddr,
	input	logic						imem_awvalid,
	output	logic						imem_awready,
	input	mem_pkg::word_t				imem_wdata,
	input	mem_pkg::strb_t				imem_wstrb,
	input	logic						imem_wvalid,
	output	logic						imem_wready,
	output	mem_pkg::axi_resp_t			imem_bresp,
	output	logic						imem_bvalid,
	input	logic						imem_bready,
	input	logic	[`MEM_ADDR_W-1:0]	imem_araddr,
	input	logic						imem_arvalid,
	output	logic						imem_arready,
	output	mem_pkg::word_t				imem_rdata,
	output	mem_pkg::axi_resp_t			imem_rresp,
	output	logic						imem_rvalid,
	input	logic						imem_rready,

	// dmem port
	input	logic	[`MEM_ADDR_W-1:0]	dmem_awaddr,
	input	logic						dmem_awvalid,
	output	logic						dmem_awready,
	input	mem_pkg::word_t				dmem_wdata,
	input	mem_pkg::strb_t				dmem_wstrb,
	input	logic						dmem_wvalid,
	output	logic						dmem_wready,
	output	mem_pkg::axi_resp_t			dmem_bresp,
	output	logic						dmem_bvalid,
	input	logic						dmem_bready,
	input	logic	[`MEM_ADDR_W-1:0]	dmem_araddr,
	input	logic						dmem_arvalid,
	output	logic						dmem_arready,
	output	mem_pkg::word_t				dmem_rdata,
	output	mem_pkg::axi_resp_t			dmem_rresp,
	output	logic						dmem_rvalid,
	input	logic						dmem_rready
);

	logic				btn_reset;
	logic				core_reset;

	logic				bram_en_a;
	mem_pkg::strb_t		bram_we_a;
	mem_pkg::waddr_t	bram_addr_a;
	mem_pkg::word_t		bram_wrdata_a;
	mem_pkg::word_t		bram_rddata_a;

	logic				bram_en_b;
	mem_pkg::strb_t		bram_we_b;
	mem_pkg::waddr_t	bram_addr_b;
	mem_pkg::word_t		bram_wrdata_b;
	mem_pkg::word_t		bram_rddata_b;

	// either source resets the bridges, the RAM keeps its contents
	assign core_reset = reset || btn_reset;

	reset_debounce
	#(
		.TICKS			(DEBOUNCE_TICKS)
	) debounce_inst
	(
		.clk			(clk),
		.reset			(reset),
		.reset_btn		(reset_btn),
		.btn_reset		(btn_reset)
	);

	axil_bram_ctrl imem_ctrl
	(
		.clk			(clk),
		.reset			(core_reset),
		.awaddr			(imem_awaddr),
		.awvalid		(imem_awvalid),
		.awready		(imem_awready),
		.wdata			(imem_wdata),
		.wstrb			(imem_wstrb),
		.wvalid			(imem_wvalid),
		.wready			(imem_wready),
		.bresp			(imem_bresp),
		.bvalid			(imem_bvalid),
		.bready			(imem_bready),
		.araddr			(imem_araddr),
		.arvalid		(imem_arvalid),
		.arready		(imem_arready),
		.rdata			(imem_rdata),
		.rresp			(imem_rresp),
		.rvalid			(imem_rvalid),
		.rready			(imem_rready),
		.bram_en		(bram_en_a),
		.bram_we		(bram_we_a),
		.bram_addr		(bram_addr_a),
		.bram_wrdata	(bram_wrdata_a),
		.bram_rddata	(bram_rddata_a)
	);

	axil_bram_ctrl dmem_ctrl
	(
		.clk			(clk),
		.reset			(core_reset),
		.awaddr			(dmem_awaddr),
		.awvalid		(dmem_awvalid),
		.awready		(dmem_awready),
		.wdata			(dmem_wdata),
		.wstrb			(dmem_wstrb),
		.wvalid			(dmem_wvalid),
		.wready			(dmem_wready),
		.bresp			(dmem_bresp),
		.bvalid			(dmem_bvalid),
		.bready			(dmem_bready),
		.araddr			(dmem_araddr),
		.arvalid		(dmem_arvalid),
		.arready		(dmem_arready),
		.rdata			(dmem_rdata),
		.rresp			(dmem_rresp),
		.rvalid			(dmem_rvalid),
		.rready			(dmem_rready),
		.bram_en		(bram_en_b),
		.bram_we		(bram_we_b),
		.bram_addr		(bram_addr_b),
		.bram_wrdata	(bram_wrdata_b),
		.bram_rddata	(bram_rddata_b)
	);

	dual_port_bram ram_inst
	(
		.clk			(clk),
		.ena			(bram_en_a),
		.wea			(bram_we_a),
		.addra			(bram_addr_a),
		.dina			(bram_wrdata_a),
		.douta			(bram_rddata_a),
		.enb			(bram_en_b),
		.web			(bram_we_b),
		.addrb			(bram_addr_b),
		.dinb			(bram_wrdata_b),
		.doutb			(bram_rddata_b)
	);

endmodule

// File: tb/mem_checker.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_checker
(
	input	logic						clk,
	input	logic						reset,
	input	logic						expect_idle,
	input	mem_pkg::axi_resp_t			exp_resp [2],
	input	logic	[`MEM_ADDR_W-1:0]	awaddr [2],
	input	logic	[1:0]				awvalid,
	input	logic	[1:0]				awready,
	input	mem_pkg::word_t				wdata [2],
	input	mem_pkg::strb_t				wstrb [2],
	input	logic	[1:0]				wvalid,
	input	logic	[1:0]				wready,
	input	mem_pkg::axi_resp_t			bresp [2],
	input	logic	[1:0]				bvalid,
	input	logic	[1:0]				bready,
	input	logic	[`MEM_ADDR_W-1:0]	araddr [2],
	input	logic	[1:0]				arvalid,
	input	logic	[1:0]				arready,
	input	mem_pkg::word_t				rdata [2],
	input	mem_pkg::axi_resp_t			rresp [2],
	input	logic	[1:0]				rvalid,
	input	logic	[1:0]				rready
);

	localparam	LIMIT	= 40;

	mem_pkg::word_t		shadow [0:`MEM_WORDS-1];
	mem_pkg::word_t		exp_rdata [2];
	logic	[1:0]		pend_b;
	logic	[1:0]		pend_r;
	int					wait_cnt [2];
	int					data_errors = 0;
	int					proto_errors = 0;

	// pre-edge values of all ports are seen here
	always @(posedge clk) begin
		mem_pkg::waddr_t	wa;

		if (reset) begin
			pend_b = '0;
			pend_r = '0;
			wait_cnt[0] = 0;
			wait_cnt[1] = 0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (awready[p] !== wready[p]) begin
					$display("%0t: port %0d awready and wready differ", $time, p);
					proto_errors++;
				end

				// shadow follows the byte strobes and skips unmapped writes
				if (awvalid[p] && awready[p] && wvalid[p] && wready[p]) begin
					if (int'(awaddr[p]) < `MEM_WORDS * 4) begin
						wa = mem_pkg::waddr_t'(awaddr[p] >> 2);
						for (int b = 0; b < 4; b++) begin
							if (wstrb[p][b])
								shadow[wa][b*8 +: 8] = wdata[p][b*8 +: 8];
						end
					end
					pend_b[p] = 1'b1;
				end

				if (arvalid[p] && arready[p]) begin
					if (int'(araddr[p]) < `MEM_WORDS * 4)
						exp_rdata[p] = shadow[mem_pkg::waddr_t'(araddr[p] >> 2)];
					else
						exp_rdata[p] = '0;
					pend_r[p] = 1'b1;
				end

				if (bvalid[p]) begin
					if (!pend_b[p]) begin
						$display("%0t: port %0d raised bvalid without a write", $time, p);
						proto_errors++;
					end else if (bresp[p] !== exp_resp[p]) begin
						$display("Mismatch at %0t: port %0d bresp %0d, expected %0d",
							$time, p, bresp[p], exp_resp[p]);
						data_errors++;
					end
					if (bready[p])
						pend_b[p] = 1'b0;
				end

				if (rvalid[p]) begin
					if (!pend_r[p]) begin
						$display("%0t: port %0d raised rvalid without a read request", $time, p);
						proto_errors++;
					end else if (rdata[p] !== exp_rdata[p] || rresp[p] !== exp_resp[p]) begin
						$display("Mismatch at %0t: port %0d rdata %h rresp %0d, expected %h %0d",
							$time, p, rdata[p], rresp[p], exp_rdata[p], exp_resp[p]);
						data_errors++;
					end
					if (rready[p])
						pend_r[p] = 1'b0;
				end

				// accepted but no response yet
				if ((pend_b[p] && !bvalid[p]) || (pend_r[p] && !rvalid[p]))
					wait_cnt[p]++;
				else
					wait_cnt[p] = 0;
				if (wait_cnt[p] == LIMIT) begin
					$display("%0t: port %0d response never arrived", $time, p);
					proto_errors++;
				end

				if ((bvalid[p] || rvalid[p]) && (awready[p] || arready[p])) begin
					$display("%0t: port %0d accepted a request with a response pending", $time, p);
					proto_errors++;
				end
				if (expect_idle && (awready[p] || arready[p])) begin
					$display("%0t: port %0d accepted a request during the button reset", $time, p);
					proto_errors++;
				end
			end
		end
	end

endmodule

// File: tb/tb_fpga_mem_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_fpga_mem_top;

	localparam				TBL_LEN		= 17;
	localparam				LFSR_SEED	= 32'hec32_c758;
	localparam				BTN_CYCLES	= 200;
	localparam				WAIT_MAX	= 40;
	localparam	logic		IMEM		= 1'b0;
	localparam	logic		DMEM		= 1'b1;
	localparam	logic		RD			= 1'b0;
	localparam	logic		WR			= 1'b1;
	localparam	logic [1:0]	OK			= 2'b00;
	localparam	logic [1:0]	ERR			= 2'b10;

	// delay of 4'hf means a random delay
	typedef struct packed {
		logic			port;
		logic			wr;
		logic	[15:0]	addr;
		logic	[3:0]	strb;
		logic			rnd;
		logic	[31:0]	data;
		logic	[3:0]	delay;
		logic	[1:0]	resp;
	} entry_t;

	logic						clk;
	logic						reset;
	logic						reset_btn;
	logic						expect_idle;
	mem_pkg::axi_resp_t			exp_resp [2];
	logic	[`MEM_ADDR_W-1:0]	awaddr [2];
	logic	[1:0]				awvalid;
	logic	[1:0]				awready;
	mem_pkg::word_t				wdata [2];
	mem_pkg::strb_t				wstrb [2];
	logic	[1:0]				wvalid;
	logic	[1:0]				wready;
	mem_pkg::axi_resp_t			bresp [2];
	logic	[1:0]				bvalid;
	logic	[1:0]				bready;
	logic	[`MEM_ADDR_W-1:0]	araddr [2];
	logic	[1:0]				arvalid;
	logic	[1:0]				arready;
	mem_pkg::word_t				rdata [2];
	mem_pkg::axi_resp_t			rresp [2];
	logic	[1:0]				rvalid;
	logic	[1:0]				rready;
	entry_t						tbl [TBL_LEN];
	logic	[31:0]				lfsr;
	int							drv_errors;

	fpga_mem_top
	#(
		.DEBOUNCE_TICKS	(4)
	) uut
	(
		.clk			(clk),
		.reset			(reset),
		.reset_btn		(reset_btn),
		.imem_awaddr	(awaddr[0]),
		.imem_awvalid	(awvalid[0]),
		.imem_awready	(awready[0]),
		.imem_wdata		(wdata[0]),
		.imem_wstrb		(wstrb[0]),
		.imem_wvalid	(wvalid[0]),
		.imem_wready	(wready[0]),
		.imem_bresp		(bresp[0]),
		.imem_bvalid	(bvalid[0]),
		.imem_bready	(bready[0]),
		.imem_araddr	(araddr[0]),
		.imem_arvalid	(arvalid[0]),
		.imem_arready	(arready[0]),
		.imem_rdata		(rdata[0]),
		.imem_rresp		(rresp[0]),
		.imem_rvalid	(rvalid[0]),
		.imem_rready	(rready[0]),
		.dmem_awaddr	(awaddr[1]),
		.dmem_awvalid	(awvalid[1]),
		.dmem_awready	(awready[1]),
		.dmem_wdata		(wdata[1]),
		.dmem_wstrb		(wstrb[1]),
		.dmem_wvalid	(wvalid[1]),
		.dmem_wready	(wready[1]),
		.dmem_bresp		(bresp[1]),
		.dmem_bvalid	(bvalid[1]),
		.dmem_bready	(bready[1]),
		.dmem_araddr	(araddr[1]),
		.dmem_arvalid	(arvalid[1]),
		.dmem_arready	(arready[1]),
		.dmem_rdata		(rdata[1]),
		.dmem_rresp		(rresp[1]),
		.dmem_rvalid	(rvalid[1]),
		.dmem_rready	(rready[1])
	);

	mem_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic entry_t mk(input logic port, input logic wr, input logic [15:0] addr,
			input logic [3:0] strb, input logic rnd, input logic [31:0] data,
			input logic [3:0] delay, input logic [1:0] resp);
		return {port, wr, addr, strb, rnd, data, delay, resp};
	endfunction

	function automatic logic flag(input int which, input int p);
		case (which)
			0: return awready[p];
			1: return arready[p];
			2: return bvalid[p];
			default: return rvalid[p];
		endcase
	endfunction

	// returns on the falling edge where the flag is seen
	task automatic wait_flag(input int which, input int p, input string name);
		int n;

		n = 0;
		@(negedge clk);
		while (!flag(which, p) && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (!flag(which, p)) begin
			$display("%0t: port %0d never raised %s", $time, p, name);
			drv_errors++;
		end
	endtask

	task automatic take_resp(input int which, input int p, input int delay);
		wait_flag(which, p, (which == 2) ? "bvalid" : "rvalid");
		repeat (delay) @(negedge clk);
		if (which == 2)
			bready[p] = 1'b1;
		else
			rready[p] = 1'b1;
		@(negedge clk);
		bready[p] = 1'b0;
		rready[p] = 1'b0;
	endtask

	task automatic start_read(input int p, input logic [`MEM_ADDR_W-1:0] addr);
		araddr[p] = addr;
		arvalid[p] = 1'b1;
	endtask

	task automatic finish_read(input int p, input int delay);
		wait_flag(1, p, "arready");
		@(negedge clk);
		arvalid[p] = 1'b0;
		take_resp(3, p, delay);
	endtask

	task automatic do_write(input int p, input entry_t e, input logic [31:0] data,
			input int delay);
		awaddr[p] = e.addr;
		wdata[p] = data;
		wstrb[p] = e.strb;
		awvalid[p] = 1'b1;
		wvalid[p] = 1'b1;
		wait_flag(0, p, "awready");
		@(negedge clk);
		awvalid[p] = 1'b0;
		wvalid[p] = 1'b0;
		// read of the same word queued behind the held response
		if (delay > 0)
			start_read(p, e.addr);
		take_resp(2, p, delay);
		if (delay > 0)
			finish_read(p, 0);
	endtask

	initial begin
		entry_t			e;
		logic	[31:0]	data;
		logic	[31:0]	d;
		int				delay;
		int				p;

		lfsr = LFSR_SEED;
		drv_errors = 0;
		reset = 1'b1;
		reset_btn = 1'b0;
		expect_idle = 1'b0;
		awvalid = '0;
		wvalid = '0;
		bready = '0;
		arvalid = '0;
		rready = '0;
		for (int i = 0; i < 2; i++) begin
			awaddr[i] = '0;
			wdata[i] = '0;
			wstrb[i] = '0;
			araddr[i] = '0;
			exp_resp[i] = mem_pkg::resp_okay;
		end

		tbl[0]  = mk(IMEM, WR, 16'h0010, 4'hf, 1'b0, 32'h1234_5678, 4'd0, OK);
		tbl[1]  = mk(IMEM, RD, 16'h0010, 4'h0, 1'b0, 32'h0, 4'd0, OK);
		tbl[2]  = mk(DMEM, WR, 16'h0200, 4'hf, 1'b1, 32'h0, 4'd0, OK);
		tbl[3]  = mk(DMEM, RD, 16'h0200, 4'h0, 1'b0, 32'h0, 4'hf, OK);
		tbl[4]  = mk(DMEM, WR, 16'h0024, 4'hf, 1'b0, 32'hdead_beef, 4'd0, OK);
		tbl[5]  = mk(DMEM, WR, 16'h0024, 4'b0101, 1'b0, 32'h0a0b_0c0d, 4'd0, OK);
		tbl[6]  = mk(IMEM, WR, 16'h0024, 4'b1000, 1'b1, 32'h0, 4'd3, OK);
		tbl[7]  = mk(DMEM, RD, 16'h0024, 4'h0, 1'b0, 32'h0, 4'd0, OK);
		tbl[8]  = mk(DMEM, WR, 16'h0300, 4'hf, 1'b0, 32'hcafe_f00d, 4'd0, OK);
		tbl[9]  = mk(IMEM, RD, 16'h0300, 4'h0, 1'b0, 32'h0, 4'd0, OK);
		tbl[10] = mk(IMEM, WR, 16'h3ffc, 4'hf, 1'b1, 32'h0, 4'd0, OK);
		tbl[11] = mk(DMEM, RD, 16'h3ffc, 4'h0, 1'b0, 32'h0, 4'd2, OK);
		tbl[12] = mk(IMEM, WR, 16'h4010, 4'hf, 1'b0, 32'hffff_ffff, 4'd0, ERR);
		tbl[13] = mk(IMEM, RD, 16'h4010, 4'h0, 1'b0, 32'h0, 4'd0, ERR);
		tbl[14] = mk(DMEM, RD, 16'h0010, 4'h0, 1'b0, 32'h0, 4'd0, OK);
		tbl[15] = mk(IMEM, RD, 16'h0200, 4'h0, 1'b0, 32'h0, 4'd6, OK);
		tbl[16] = mk(DMEM, WR, 16'hfffc, 4'hf, 1'b1, 32'h0, 4'd4, ERR);

		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);

		foreach (tbl[i]) begin
			e = tbl[i];
			p = int'(e.port);
			data = e.data;
			if (e.rnd)
				take_bits(32, data);
			delay = int'(e.delay);
			if (e.delay == 4'hf) begin
				take_bits(3, d);
				delay = int'(d);
			end
			exp_resp[p] = mem_pkg::axi_resp_t'(e.resp);
			if (e.wr) begin
				do_write(p, e, data, delay);
			end else begin
				start_read(p, e.addr);
				finish_read(p, delay);
			end
		end

		// button held well past the five ticks needed to assert the core reset
		exp_resp[0] = mem_pkg::resp_okay;
		exp_resp[1] = mem_pkg::resp_okay;
		reset_btn = 1'b1;
		repeat (24) @(negedge clk);
		expect_idle = 1'b1;
		start_read(0, 16'h0010);
		start_read(1, 16'h0300);
		repeat (16) @(negedge clk);
		reset_btn = 1'b0;
		expect_idle = 1'b0;
		fork
			finish_read(0, 0);
			finish_read(1, 0);
		join

		repeat (4) @(negedge clk);
		$display("errors: data %0d, protocol %0d, driver %0d",
			chk.data_errors, chk.proto_errors, drv_errors);
		if (chk.data_errors + chk.proto_errors + drv_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		repeat (8 + TBL_LEN * 40 + BTN_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within the cycle limit");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
verilog/mem_pkg.sv
verilog/reset_debounce.sv
verilog/axil_bram_ctrl.sv
verilog/dual_port_bram.sv
verilog/fpga_mem_top.sv
tb/mem_checker.sv
tb/tb_fpga_mem_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_fpga_mem_top -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_fpga_mem_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
